// ==== logic/code_pkg.sv ====
////////////////////////////////////////////////////////////
// 8b/10b line code types and comma constants, shared by the
// encoder, the top level and the testbench
////////////////////////////////////////////////////////////

package code_pkg;

    // one transmission character, bit 0 goes on the wire first
    // bits 5:0 carry abcdei, bits 9:6 carry fghj
    typedef logic [9:0] code_group_t;

    // two characters per lane word, lo lands in bits 9:0
    typedef struct packed {
        code_group_t hi;
        code_group_t lo;
    } code_pair_t;

    // running disparity carried from one character to the next
    typedef enum logic {
        rd_neg = 1'b0,
        rd_pos = 1'b1
    } rd_t;

    // comma character byte value
    localparam logic [7:0] K28_5 = 8'hBC;

    // {is_k, byte} sent in both slots when there is nothing to send
    localparam logic [8:0] IDLE_CHAR = {1'b1, K28_5};

    // K28.5 as it appears on the lane, abcdei = 001111 / 110000
    localparam code_group_t COMMA_RD_NEG = 10'b0101111100;
    localparam code_group_t COMMA_RD_POS = 10'b1010000011;

endpackage

// ==== logic/link_pkg.sv ====
////////////////////////////////////////////////////////////
// user-side word and half-word types for the transmit path
////////////////////////////////////////////////////////////

package link_pkg;

    localparam int BYTE_BITS      = 8;
    localparam int BYTES_PER_WORD = 4;
    localparam int BYTES_PER_HALF = 2;
    localparam int WORD_BITS      = BYTES_PER_WORD * BYTE_BITS;
    localparam int HALF_BITS      = BYTES_PER_HALF * BYTE_BITS;

    // user word, one charisk flag per byte
    typedef struct packed {
        logic [WORD_BITS-1:0]      data;
        logic [BYTES_PER_WORD-1:0] charisk;
    } tx_word_t;

    // one lane's worth of bytes
    typedef struct packed {
        logic [HALF_BITS-1:0]      data;
        logic [BYTES_PER_HALF-1:0] charisk;
    } tx_half_t;

    // half plus its valid flag, splitter to encoder
    typedef struct packed {
        logic     valid;
        tx_half_t half;
    } half_slot_t;

endpackage

// ==== logic/byte_encoder.sv ====
////////////////////////////////////////////////////////////
// 8b/10b encoder for a single byte, combinational; chain two
// or more through rd_in/rd_out for a multi-byte lane
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module byte_encoder
    import code_pkg::*;
(
    input  logic [7:0]  data,
    input  logic        is_k,
    input  rd_t         rd_in,
    output code_group_t code,
    output rd_t         rd_out
);

    // 5b/6b in abcdei order with a as the msb, negative disparity form
    function automatic logic [5:0] lut_5b6b(input logic [4:0] x);
        case (x)
            5'd0:  lut_5b6b = 6'b100111;
            5'd1:  lut_5b6b = 6'b011101;
            5'd2:  lut_5b6b = 6'b101101;
            5'd3:  lut_5b6b = 6'b110001;
            5'd4:  lut_5b6b = 6'b110101;
            5'd5:  lut_5b6b = 6'b101001;
            5'd6:  lut_5b6b = 6'b011001;
            5'd7:  lut_5b6b = 6'b111000;
            5'd8:  lut_5b6b = 6'b111001;
            5'd9:  lut_5b6b = 6'b100101;
            5'd10: lut_5b6b = 6'b010101;
            5'd11: lut_5b6b = 6'b110100;
            5'd12: lut_5b6b = 6'b001101;
            5'd13: lut_5b6b = 6'b101100;
            5'd14: lut_5b6b = 6'b011100;
            5'd15: lut_5b6b = 6'b010111;
            5'd16: lut_5b6b = 6'b011011;
            5'd17: lut_5b6b = 6'b100011;
            5'd18: lut_5b6b = 6'b010011;
            5'd19: lut_5b6b = 6'b110010;
            5'd20: lut_5b6b = 6'b001011;
            5'd21: lut_5b6b = 6'b101010;
            5'd22: lut_5b6b = 6'b011010;
            5'd23: lut_5b6b = 6'b111010;
            5'd24: lut_5b6b = 6'b110011;
            5'd25: lut_5b6b = 6'b100110;
            5'd26: lut_5b6b = 6'b010110;
            5'd27: lut_5b6b = 6'b110110;
            5'd28: lut_5b6b = 6'b001110;
            5'd29: lut_5b6b = 6'b101110;
            5'd30: lut_5b6b = 6'b011110;
            5'd31: lut_5b6b = 6'b101011;
        endcase
    endfunction

    // 3b/4b in fghj order with f as the msb, negative disparity form
    // y = 7 gives the primary encoding here
    function automatic logic [3:0] lut_3b4b(input logic [2:0] y);
        case (y)
            3'd0: lut_3b4b = 4'b1011;
            3'd1: lut_3b4b = 4'b1001;
            3'd2: lut_3b4b = 4'b0101;
            3'd3: lut_3b4b = 4'b1100;
            3'd4: lut_3b4b = 4'b1101;
            3'd5: lut_3b4b = 4'b1010;
            3'd6: lut_3b4b = 4'b0110;
            3'd7: lut_3b4b = 4'b1110;
        endcase
    endfunction

    logic [4:0] x;
    logic [2:0] y;
    logic       k28;
    logic       k_x7;
    logic [5:0] six_neg;
    logic [5:0] abcdei;
    logic       six_unbal;
    rd_t        rd_mid;
    logic       alt7;
    logic [3:0] four_neg;
    logic [3:0] fghj;
    logic       four_unbal;
    logic       flip4;

    assign x = data[4:0];
    assign y = data[7:5];

    // control forms; any other k byte falls back to the data code
    assign k28  = is_k && (x == 5'd28);
    assign k_x7 = is_k && (y == 3'd7) && (x inside {5'd23, 5'd27, 5'd29, 5'd30});

    always_comb begin
        six_neg   = k28 ? 6'b001111 : lut_5b6b(x);
        six_unbal = ($countones(six_neg) != 3);

        // D.07 is balanced but still alternates with disparity
        if ((rd_in == rd_pos) && (six_unbal || (x == 5'd7))) begin
            abcdei = ~six_neg;
        end else begin
            abcdei = six_neg;
        end
        if (six_unbal) begin
            rd_mid = (rd_in == rd_neg) ? rd_pos : rd_neg;
        end else begin
            rd_mid = rd_in;
        end

        // alternate x.7 avoids a run of five equal bits across the boundary
        alt7 = (y == 3'd7) && (k28 || k_x7 ||
               ((rd_mid == rd_neg) && (x inside {5'd17, 5'd18, 5'd20})) ||
               ((rd_mid == rd_pos) && (x inside {5'd11, 5'd13, 5'd14})));

        four_neg   = alt7 ? 4'b0111 : lut_3b4b(y);
        four_unbal = ($countones(four_neg) != 2);

        // K28.1/.2/.5/.6 use the inverted sense of the neutral codes
        if (k28 && (y inside {3'd1, 3'd2, 3'd5, 3'd6})) begin
            flip4 = (rd_mid == rd_neg);
        end else begin
            flip4 = (rd_mid == rd_pos) && (four_unbal || (y == 3'd3));
        end
        fghj = flip4 ? ~four_neg : four_neg;

        if (four_unbal) begin
            rd_out = (rd_mid == rd_neg) ? rd_pos : rd_neg;
        end else begin
            rd_out = rd_mid;
        end
    end

    // a goes to bit 0, j to bit 9
    assign code = {fghj[0], fghj[1], fghj[2], fghj[3],
                   abcdei[0], abcdei[1], abcdei[2], abcdei[3], abcdei[4], abcdei[5]};

endmodule

// ==== logic/word_splitter.sv ====
////////////////////////////////////////////////////////////
// takes a user word over a four-phase req/ack handshake and
// hands it on as two half slots, low half first
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module word_splitter
    import link_pkg::*;
(
    input  logic       txusrclk,
    input  logic       rst_n,
    input  logic       tx_req,
    output logic       tx_ack,
    input  tx_word_t   tx_word,
    output half_slot_t half_slot
);

    typedef enum logic [1:0] {
        idle,
        send_lo,
        send_hi,
        wait_release
    } state_t;

    state_t     state;
    state_t     state_nxt;
    tx_word_t   word_q;
    half_slot_t slot_nxt;
    logic       accept;

    // a word is taken only with no half in flight and ack already dropped
    assign accept = (state == idle) && tx_req && !tx_ack;

    always_comb begin
        state_nxt = state;
        case (state)
            idle: begin
                if (accept) begin
                    state_nxt = send_lo;
                end
            end
            send_lo: begin
                state_nxt = send_hi;
            end
            send_hi: begin
                // user may still be holding req, then ack has to come down first
                state_nxt = (tx_ack && tx_req) ? wait_release : idle;
            end
            wait_release: begin
                if (!tx_req) begin
                    state_nxt = idle;
                end
            end
            default: begin
                state_nxt = idle;
            end
        endcase
    end

    always_comb begin
        slot_nxt = '0;
        if (state == send_lo) begin
            slot_nxt.valid        = 1'b1;
            slot_nxt.half.data    = word_q.data[HALF_BITS-1:0];
            slot_nxt.half.charisk = word_q.charisk[BYTES_PER_HALF-1:0];
        end else if (state == send_hi) begin
            slot_nxt.valid        = 1'b1;
            slot_nxt.half.data    = word_q.data[WORD_BITS-1:HALF_BITS];
            slot_nxt.half.charisk = word_q.charisk[BYTES_PER_WORD-1:BYTES_PER_HALF];
        end
    end

    always_ff @(posedge txusrclk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= idle;
            tx_ack    <= 1'b0;
            half_slot <= '0;
        end else begin
            state     <= state_nxt;
            half_slot <= slot_nxt;
            if (accept) begin
                tx_ack <= 1'b1;
            end else if (!tx_req) begin
                tx_ack <= 1'b0;
            end
        end
    end

    always_ff @(posedge txusrclk) begin
        if (accept) begin
            word_q <= tx_word;
        end
    end

endmodule

// ==== logic/pair_encoder.sv ====
////////////////////////////////////////////////////////////
// encodes one half slot per clock into a registered 20-bit
// lane word, idle commas fill the slots with nothing to send
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module pair_encoder
    import code_pkg::*;
    import link_pkg::*;
(
    input  logic       txusrclk,
    input  logic       rst_n,
    input  half_slot_t half_slot,
    output code_pair_t lane
);

    rd_t                  rd_q;
    rd_t                  rd_mid;
    rd_t                  rd_next;
    logic [BYTE_BITS-1:0] byte_lo;
    logic [BYTE_BITS-1:0] byte_hi;
    logic                 k_lo;
    logic                 k_hi;
    code_group_t          code_lo;
    code_group_t          code_hi;

    always_comb begin
        if (half_slot.valid) begin
            byte_lo = half_slot.half.data[BYTE_BITS-1:0];
            byte_hi = half_slot.half.data[2*BYTE_BITS-1:BYTE_BITS];
            k_lo    = half_slot.half.charisk[0];
            k_hi    = half_slot.half.charisk[1];
        end else begin
            {k_lo, byte_lo} = IDLE_CHAR;
            {k_hi, byte_hi} = IDLE_CHAR;
        end
    end

    // low byte goes first on the wire, so it sees the stored disparity
    byte_encoder enc_lo (
        .data   (byte_lo),
        .is_k   (k_lo),
        .rd_in  (rd_q),
        .code   (code_lo),
        .rd_out (rd_mid)
    );

    byte_encoder enc_hi (
        .data   (byte_hi),
        .is_k   (k_hi),
        .rd_in  (rd_mid),
        .code   (code_hi),
        .rd_out (rd_next)
    );

    always_ff @(posedge txusrclk or negedge rst_n) begin
        if (!rst_n) begin
            rd_q    <= rd_neg;
            lane.hi <= COMMA_RD_NEG;
            lane.lo <= COMMA_RD_NEG;
        end else begin
            rd_q    <= rd_next;
            lane.hi <= code_hi;
            lane.lo <= code_lo;
        end
    end

endmodule

// ==== logic/tx_pcs_top.sv ====
////////////////////////////////////////////////////////////
// transmit PCS top, user word handshake in, encoded 20-bit
// lane out, all on txusrclk
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tx_pcs_top
    import code_pkg::*;
    import link_pkg::*;
(
    input  logic       txusrclk,
    input  logic       rst_n,
    input  logic       tx_req,
    output logic       tx_ack,
    input  tx_word_t   tx_word,
    output code_pair_t lane
);

    // one half per clock, no back-pressure on this path
    half_slot_t half_slot;

    word_splitter word_splitter_inst (
        .txusrclk  (txusrclk),
        .rst_n     (rst_n),
        .tx_req    (tx_req),
        .tx_ack    (tx_ack),
        .tx_word   (tx_word),
        .half_slot (half_slot)
    );

    pair_encoder pair_encoder_inst (
        .txusrclk  (txusrclk),
        .rst_n     (rst_n),
        .half_slot (half_slot),
        .lane      (lane)
    );

endmodule

// ==== dv/tb_code_table.svh ====
////////////////////////////////////////////////////////////
// expected 8b/10b code groups of the characters the testbench
// sends, included inside the testbench module
////////////////////////////////////////////////////////////

`ifndef TB_CODE_TABLE_SVH
`define TB_CODE_TABLE_SVH

localparam int NUM_CHARS = 6;

// {charisk, byte} of each table entry
function automatic logic [8:0] char_of(input int idx);
    case (idx)
        0:       char_of = {1'b0, 8'h00};
        1:       char_of = {1'b0, 8'hB5};
        2:       char_of = {1'b0, 8'h4A};
        3:       char_of = {1'b0, 8'hFF};
        4:       char_of = {1'b0, 8'hE3};
        // K23.7, its fghj uses the alternate x.7 form
        default: char_of = {1'b1, 8'hF7};
    endcase
endfunction

// rows are abcdei_fghj with a leftmost, negative then positive disparity
function automatic logic [9:0] code_of(input int idx, input rd_t rd);
    logic [9:0] neg;
    logic [9:0] pos;
    case (idx)
        0:       {neg, pos} = {10'b100111_0100, 10'b011000_1011};
        1:       {neg, pos} = {10'b101010_1010, 10'b101010_1010};
        2:       {neg, pos} = {10'b010101_0101, 10'b010101_0101};
        3:       {neg, pos} = {10'b101011_0001, 10'b010100_1110};
        4:       {neg, pos} = {10'b110001_1110, 10'b110001_0001};
        default: {neg, pos} = {10'b111010_1000, 10'b000101_0111};
    endcase
    return (rd == rd_pos) ? pos : neg;
endfunction

`endif

// ==== dv/tb_tx_pcs.sv ====
////////////////////////////////////////////////////////////
// testbench for the transmit PCS, sends random words over the
// req/ack handshake and checks every lane code group
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_tx_pcs
    import code_pkg::*;
    import link_pkg::*;
();

    localparam int NUM_WORDS     = 40;
    localparam int ACK_TIMEOUT   = 50;
    localparam int DRAIN_TIMEOUT = 50;

    `include "tb_code_table.svh"

    logic       txusrclk = 1'b0;
    logic       rst_n;
    logic       tx_req;
    logic       tx_ack;
    tx_word_t   tx_word;
    code_pair_t lane;

    integer seed;
    // byte table indices in lane order, filled by the stimulus only
    int     expect_q[$];
    logic   monitor_on = 1'b0;
    // monitor state
    int     read_ptr   = 0;
    int     words_seen = 0;
    logic   hi_pending = 1'b0;
    rd_t    rd_track   = rd_neg;

    tx_pcs_top tx_pcs_top_inst (
        .txusrclk (txusrclk),
        .rst_n    (rst_n),
        .tx_req   (tx_req),
        .tx_ack   (tx_ack),
        .tx_word  (tx_word),
        .lane     (lane)
    );

    always #5 txusrclk = ~txusrclk;

    task automatic report_mismatch(input string msg);
        $display("MISMATCH at %0t ns: %s", $time, msg);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic abort_run(input string msg);
        $display("ERROR: %s", msg);
        $display("test failed");
        $fatal(1);
    endtask

    // handshake order, ack moves only in response to req
    assert property (@(posedge txusrclk) disable iff (!rst_n)
        $rose(tx_ack) |-> $past(tx_req))
        else report_mismatch("tx_ack rose while tx_req was low");

    assert property (@(posedge txusrclk) disable iff (!rst_n)
        $fell(tx_ack) |-> !$past(tx_req))
        else report_mismatch("tx_ack fell while tx_req was high");

    // a goes out first and sits in bit 0
    function automatic code_group_t to_lane(input logic [9:0] std);
        code_group_t g;
        for (int i = 0; i < 10; i++) begin
            g[i] = std[9-i];
        end
        return g;
    endfunction

    function automatic code_group_t comma_for(input rd_t rd);
        return (rd == rd_pos) ? COMMA_RD_POS : COMMA_RD_NEG;
    endfunction

    // weight and disparity first, then the exact group,
    // then step the tracked disparity by its weight
    task automatic check_group(input code_group_t got, input code_group_t want,
                               input string what);
        int ones;
        ones = $countones(got);
        assert (ones >= 4 && ones <= 6)
            else report_mismatch($sformatf("%s %b has %0d ones", what, got, ones));
        assert (!(ones == 6 && rd_track == rd_pos) && !(ones == 4 && rd_track == rd_neg))
            else report_mismatch($sformatf("%s %b repeats the disparity sign", what, got));
        assert (got == want)
            else report_mismatch($sformatf("%s got %b, expected %b", what, got, want));
        if (ones == 6) begin
            rd_track = rd_pos;
        end else if (ones == 4) begin
            rd_track = rd_neg;
        end
    endtask

    task automatic sample_lane();
        if (lane.lo == COMMA_RD_NEG || lane.lo == COMMA_RD_POS) begin
            assert (!hi_pending)
                else report_mismatch("idle pair between the two halves of a word");
            check_group(lane.lo, comma_for(rd_track), "idle lo");
            check_group(lane.hi, comma_for(rd_track), "idle hi");
        end else begin
            assert (read_ptr + 1 < expect_q.size())
                else abort_run("lane carries data while no word is outstanding");
            check_group(lane.lo, to_lane(code_of(expect_q[read_ptr], rd_track)), "data lo");
            check_group(lane.hi, to_lane(code_of(expect_q[read_ptr + 1], rd_track)),
                        "data hi");
            read_ptr = read_ptr + 2;
            if (hi_pending) begin
                words_seen++;
            end
            hi_pending = !hi_pending;
        end
    endtask

    initial begin
        forever begin
            @(negedge txusrclk);
            if (monitor_on) begin
                sample_lane();
            end
        end
    end

    task automatic wait_ack(input logic level);
        int cycles;
        cycles = 0;
        while (tx_ack !== level && cycles < ACK_TIMEOUT) begin
            @(negedge txusrclk);
            cycles++;
        end
        assert (tx_ack === level)
            else abort_run($sformatf("tx_ack did not go to %0b within %0d cycles",
                                     level, ACK_TIMEOUT));
    endtask

    task automatic send_word();
        tx_word_t   word;
        logic [8:0] ch;
        int         idx;
        for (int b = 0; b < BYTES_PER_WORD; b++) begin
            idx = $unsigned($random(seed)) % NUM_CHARS;
            ch  = char_of(idx);
            word.data[8*b +: 8] = ch[7:0];
            word.charisk[b]     = ch[8];
            expect_q.push_back(idx);
        end
        tx_word = word;
        tx_req  = 1'b1;
        wait_ack(1'b1);
        tx_req = 1'b0;
        wait_ack(1'b0);
    endtask

    initial begin
        int gap;
        int cycles;
        rst_n   = 1'b0;
        tx_req  = 1'b0;
        tx_word = '0;
        seed    = 7;
        repeat (3) @(negedge txusrclk);
        rst_n = 1'b1;
        assert (tx_ack == 1'b0)
            else report_mismatch("tx_ack is high after reset");
        assert (lane.lo == COMMA_RD_NEG && lane.hi == COMMA_RD_NEG)
            else report_mismatch($sformatf("lane is %h after reset", lane));
        // monitor picks up from the next falling edge
        monitor_on <= 1'b1;

        for (int w = 0; w < NUM_WORDS; w++) begin
            send_word();
            // req held low for a while, the lane has to idle meanwhile
            gap = $unsigned($random(seed)) % 4;
            repeat (gap) @(negedge txusrclk);
        end

        cycles = 0;
        while ((read_ptr < expect_q.size() || hi_pending) && cycles < DRAIN_TIMEOUT) begin
            @(negedge txusrclk);
            cycles++;
        end
        @(negedge txusrclk);
        assert (words_seen == NUM_WORDS)
            else abort_run($sformatf("only %0d of %0d words reached the lane",
                                     words_seen, NUM_WORDS));
        $display("test passed");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+dv
logic/code_pkg.sv
logic/link_pkg.sv
logic/byte_encoder.sv
logic/word_splitter.sv
logic/pair_encoder.sv
logic/tx_pcs_top.sv
dv/tb_tx_pcs.sv

// ==== run.sh ====
#!/bin/sh
# compile the transmit PCS testbench with Verilator and run it
cd "$(dirname "$0")" \
    && verilator --binary --assert --top-module tb_tx_pcs -f verilog.f -o tb_tx_pcs \
    && ./obj_dir/tb_tx_pcs \
    || exit 1
